/* all_force_caches.f */
+incdir+include
src/md_force_pkg.sv
src/md_cache_pkg.sv
src/force_input_fifo.sv
src/force_accum_cache.sv
src/force_wb_controller.sv
src/all_force_caches.sv
verification/all_force_caches_tb.sv

/* include/force_cache_settings.svh */
`ifndef FORCE_CACHE_SETTINGS_SVH
`define FORCE_CACHE_SETTINGS_SVH

// width of one force component.
`define FORCE_DATA_WIDTH 32

// particle id, also the cache address.
`define PARTICLE_ID_WIDTH 7

`define FORCE_CACHE_DEPTH 128 // entries per cell cache.

`define NUM_CELLS 4

`define FIFO_DEPTH 8 // pending writes per cell.

`endif

/* run_sim.sh */
#!/bin/sh
# compile and run the force write-back testbench with Verilator.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f all_force_caches.f \
	--top-module all_force_caches_tb -Mdir obj_dir; then
	echo "verilator compile failed"
	exit 1
fi

output=$(./obj_dir/Vall_force_caches_tb)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "All tests passed"; then
	exit 0
fi

echo "pass message not found in simulation output"
exit 1

/* src/all_force_caches.sv */
`timescale 1ns/1ns
`include "force_cache_settings.svh"

module all_force_caches
(
	input logic clk,
	input logic rst,
	input logic [`NUM_CELLS-1:0] mu_rd_request,
	input md_force_pkg::particle_id_t mu_rd_addr, // shared by all cells.
	input md_cache_pkg::force_entry_t force_and_addr_in [`NUM_CELLS],
	input logic [`NUM_CELLS-1:0] force_wr_enable,

	output logic all_force_input_buffer_empty,
	output md_cache_pkg::mu_force_t force_to_mu [`NUM_CELLS]
);

	logic [`NUM_CELLS-1:0] cell_buffer_empty;

	// motion update may read only once every cell has drained.
	assign all_force_input_buffer_empty = &cell_buffer_empty;

	genvar i;
	generate
		for (i = 0; i < `NUM_CELLS; i = i + 1)
		begin: force_caches
			force_wb_controller i_force_wb_controller
			(
				.clk(clk),
				.rst(rst),
				.wr_enable(force_wr_enable[i]),
				.force_in(force_and_addr_in[i]),
				.rd_enable(mu_rd_request[i]),
				.force_rd_addr(mu_rd_addr),
				.input_buffer_empty(cell_buffer_empty[i]),
				.force_to_mu(force_to_mu[i])
			);
		end
	endgenerate

endmodule

/* src/force_accum_cache.sv */
`timescale 1ns/1ns
`include "force_cache_settings.svh"

module force_accum_cache
(
	input logic clk,
	input logic rst,
	input logic acc_start,
	input md_cache_pkg::force_entry_t acc_entry,
	input logic rd_enable,
	input md_force_pkg::particle_id_t rd_addr,
	output logic busy,
	output md_cache_pkg::mu_force_t rd_data
);

	import md_force_pkg::*;
	import md_cache_pkg::*;

	force_vec_t mem [`FORCE_CACHE_DEPTH];
	logic [`FORCE_CACHE_DEPTH-1:0] entry_valid; // entry holds force since last read.

	// second cycle of the read-modify-write.
	logic acc_pending;
	particle_id_t acc_id;
	force_vec_t acc_add;
	force_vec_t acc_old;
	force_vec_t acc_sum;
	logic rd_hit;

	assign busy = acc_pending;
	assign acc_sum = vec_add(acc_old, acc_add);
	assign rd_hit = rd_enable && entry_valid[rd_addr];

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			acc_pending <= 1'b0;
			entry_valid <= '0;
			rd_data <= '0;
		end
		else
		begin
			acc_pending <= acc_start;

			// valid is a one cycle pulse.
			rd_data <= make_response(rd_hit, rd_addr, mem[rd_addr]);

			// read and clear, next step starts from zero.
			if (rd_enable)
				entry_valid[rd_addr] <= 1'b0;
			if (acc_pending)
				entry_valid[acc_id] <= 1'b1;
		end
	end

	// first cycle: fetch the stored sum, zero if the entry is stale.
	always_ff @(posedge clk)
	begin
		if (acc_start)
		begin
			acc_id <= acc_entry.id;
			acc_add <= acc_entry.force_vec;
			if (entry_valid[acc_entry.id])
				acc_old <= mem[acc_entry.id];
			else
				acc_old <= '0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (acc_pending)
			mem[acc_id] <= acc_sum; // write back in the second cycle.
	end

endmodule

/* src/force_input_fifo.sv */
`timescale 1ns/1ns
`include "force_cache_settings.svh"

module force_input_fifo
(
	input logic clk,
	input logic rst,
	input logic push,
	input md_cache_pkg::force_entry_t push_data,
	input logic pop,
	output md_cache_pkg::force_entry_t head,
	output logic empty
);

	import md_cache_pkg::*;

	localparam int PTR_WIDTH = (`FIFO_DEPTH > 1) ? $clog2(`FIFO_DEPTH) : 1;
	localparam int CNT_WIDTH = $clog2(`FIFO_DEPTH + 1);

	force_entry_t buffer [`FIFO_DEPTH];
	logic [PTR_WIDTH-1:0] wr_ptr;
	logic [PTR_WIDTH-1:0] rd_ptr;
	logic [CNT_WIDTH-1:0] count;
	logic full;
	logic do_push;
	logic do_pop;

	// pointer step with wrap, depth need not be a power of two.
	function automatic logic [PTR_WIDTH-1:0] ptr_next(input logic [PTR_WIDTH-1:0] ptr);
		if (ptr == PTR_WIDTH'(`FIFO_DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign full = (count == CNT_WIDTH'(`FIFO_DEPTH));
	assign empty = (count == '0);
	assign do_push = push && !full; // writes to a full buffer are lost.
	assign do_pop = pop && !empty;
	assign head = buffer[rd_ptr]; // head shows before the pop.

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= ptr_next(wr_ptr);
			if (do_pop)
				rd_ptr <= ptr_next(rd_ptr);
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1; // push with pop keeps the count.
		end
	end

	always_ff @(posedge clk)
	begin
		if (do_push)
			buffer[wr_ptr] <= push_data;
	end

endmodule

/* src/force_wb_controller.sv */
`timescale 1ns/1ns

module force_wb_controller
(
	input logic clk,
	input logic rst,
	input logic wr_enable,
	input md_cache_pkg::force_entry_t force_in,
	input logic rd_enable,
	input md_force_pkg::particle_id_t force_rd_addr,
	output logic input_buffer_empty,
	output md_cache_pkg::mu_force_t force_to_mu
);

	import md_cache_pkg::*;

	force_entry_t fifo_head;
	logic fifo_empty;
	logic fifo_pop;
	logic cache_busy;

	// one pop every other cycle at most, since the cache is busy after a start.
	// a read from the motion update unit wins, the pop waits a cycle.
	assign fifo_pop = !fifo_empty && !cache_busy && !rd_enable;

	// a buffered write counts as pending until its sum is written.
	assign input_buffer_empty = fifo_empty && !cache_busy;

	force_input_fifo i_force_input_fifo
	(
		.clk(clk),
		.rst(rst),
		.push(wr_enable),
		.push_data(force_in),
		.pop(fifo_pop),
		.head(fifo_head),
		.empty(fifo_empty)
	);

	force_accum_cache i_force_accum_cache
	(
		.clk(clk),
		.rst(rst),
		.acc_start(fifo_pop),
		.acc_entry(fifo_head),
		.rd_enable(rd_enable),
		.rd_addr(force_rd_addr),
		.busy(cache_busy),
		.rd_data(force_to_mu)
	);

endmodule

/* src/md_cache_pkg.sv */
package md_cache_pkg;

`include "force_cache_settings.svh"

	// one write from a force pipeline.
	typedef struct packed
	{
		md_force_pkg::particle_id_t id;
		md_force_pkg::force_vec_t force_vec;
	} force_entry_t;

	// response of one cell to the motion update unit.
	// all fields are zero when valid is low.
	typedef struct packed
	{
		logic valid;
		md_force_pkg::particle_id_t id;
		md_force_pkg::force_vec_t force_vec;
	} mu_force_t;

	// response built from a stored entry.
	function automatic mu_force_t make_response(input logic hit,
		input md_force_pkg::particle_id_t addr, input md_force_pkg::force_vec_t vec);
		mu_force_t r;
		r = '0;
		if (hit)
		begin
			r.valid = 1'b1;
			r.id = addr;
			r.force_vec = vec;
		end
		return r;
	endfunction

endpackage

/* src/md_force_pkg.sv */
package md_force_pkg;

`include "force_cache_settings.svh"

	// one force component, two's complement.
	typedef logic signed [`FORCE_DATA_WIDTH-1:0] force_comp_t;

	typedef struct packed
	{
		force_comp_t fx;
		force_comp_t fy;
		force_comp_t fz;
	} force_vec_t;

	typedef logic [`PARTICLE_ID_WIDTH-1:0] particle_id_t; // doubles as cache address.

	// componentwise sum, each lane wraps at its own width.
	function automatic force_vec_t vec_add(input force_vec_t a, input force_vec_t b);
		force_vec_t s;
		s.fx = a.fx + b.fx;
		s.fy = a.fy + b.fy;
		s.fz = a.fz + b.fz;
		return s;
	endfunction

endpackage

/* verification/all_force_caches_tb.sv */
`timescale 1ns/1ns
`include "force_cache_settings.svh"

module all_force_caches_tb;

	import md_force_pkg::*;
	import md_cache_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int NUM_ROWS = 26;

	typedef struct packed
	{
		logic is_read;
		logic [`NUM_CELLS-1:0] mask;
		particle_id_t id;
		force_vec_t vec; // zero asks for a random vector per cell.
	} row_t;

	logic clk;
	logic rst;
	logic [`NUM_CELLS-1:0] mu_rd_request;
	particle_id_t mu_rd_addr;
	force_entry_t force_and_addr_in [`NUM_CELLS];
	logic [`NUM_CELLS-1:0] force_wr_enable;
	logic all_force_input_buffer_empty;
	mu_force_t force_to_mu [`NUM_CELLS];

	row_t rows [NUM_ROWS];
	int row_count;
	int error_count;
	int failed_tests;

	// reference model, one running sum per cell and id.
	force_vec_t model_sum [`NUM_CELLS][`FORCE_CACHE_DEPTH];
	logic model_valid [`NUM_CELLS][`FORCE_CACHE_DEPTH];

	all_force_caches i_all_force_caches
	(
		.clk(clk),
		.rst(rst),
		.mu_rd_request(mu_rd_request),
		.mu_rd_addr(mu_rd_addr),
		.force_and_addr_in(force_and_addr_in),
		.force_wr_enable(force_wr_enable),
		.all_force_input_buffer_empty(all_force_input_buffer_empty),
		.force_to_mu(force_to_mu)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial
	begin
		#(CLK_PERIOD * (NUM_ROWS * 40 + 10));
		$display("watchdog expired before the last row finished");
		$display("Some tests failed");
		$finish;
	end

	task automatic add_row(input logic is_read, input logic [`NUM_CELLS-1:0] mask, input int id,
		input logic [`FORCE_DATA_WIDTH-1:0] fx, input logic [`FORCE_DATA_WIDTH-1:0] fy,
		input logic [`FORCE_DATA_WIDTH-1:0] fz);
		rows[row_count].is_read = is_read;
		rows[row_count].mask = mask;
		rows[row_count].id = particle_id_t'(id);
		rows[row_count].vec.fx = fx;
		rows[row_count].vec.fy = fy;
		rows[row_count].vec.fz = fz;
		row_count++;
	endtask

	function automatic force_vec_t random_vec();
		force_vec_t v;
		v.fx = $urandom;
		v.fy = $urandom;
		v.fz = $urandom;
		return v;
	endfunction

	task automatic report_mismatch(input string name, input logic [`FORCE_DATA_WIDTH-1:0] got,
		input logic [`FORCE_DATA_WIDTH-1:0] exp);
		$display("** Error: %s = %h, expected %h", name, got, exp);
		error_count++;
	endtask

	task automatic apply_write(input row_t row);
		force_entry_t entry;
		@(posedge clk);
		for (int c = 0; c < `NUM_CELLS; c++)
		begin
			if (row.mask[c])
			begin
				entry.id = row.id;
				entry.force_vec = (row.vec == '0) ? random_vec() : row.vec;
				force_and_addr_in[c] <= entry;
				model_sum[c][row.id].fx = model_sum[c][row.id].fx + entry.force_vec.fx;
				model_sum[c][row.id].fy = model_sum[c][row.id].fy + entry.force_vec.fy;
				model_sum[c][row.id].fz = model_sum[c][row.id].fz + entry.force_vec.fz;
				model_valid[c][row.id] = 1'b1;
			end
		end
		force_wr_enable <= row.mask;
		mu_rd_request <= '0;
	endtask

	task automatic apply_read(input row_t row, input logic after_write);
		mu_force_t exp [`NUM_CELLS];
		mu_force_t got;
		string name;
		@(posedge clk);
		force_wr_enable <= '0;
		@(negedge clk);
		if (after_write && all_force_input_buffer_empty)
		begin
			$display("all_force_input_buffer_empty was high while writes were still buffered");
			error_count++;
		end
		while (!all_force_input_buffer_empty)
			@(negedge clk);
		for (int c = 0; c < `NUM_CELLS; c++)
		begin
			exp[c] = '0;
			if (row.mask[c])
			begin
				if (model_valid[c][row.id])
				begin
					exp[c].valid = 1'b1;
					exp[c].id = row.id;
					exp[c].force_vec = model_sum[c][row.id];
				end
				model_valid[c][row.id] = 1'b0; // read clears the entry.
				model_sum[c][row.id] = '0;
			end
		end
		@(posedge clk);
		mu_rd_request <= row.mask;
		mu_rd_addr <= row.id;
		@(posedge clk);
		mu_rd_request <= '0;
		@(negedge clk); // response belongs to the cycle after the strobe.
		for (int c = 0; c < `NUM_CELLS; c++)
		begin
			got = force_to_mu[c];
			name = $sformatf("force_to_mu[%0d]", c);
			if (got.valid !== exp[c].valid)
				report_mismatch({name, ".valid"}, `FORCE_DATA_WIDTH'(got.valid),
					`FORCE_DATA_WIDTH'(exp[c].valid));
			if (got.id !== exp[c].id)
				report_mismatch({name, ".id"}, `FORCE_DATA_WIDTH'(got.id), `FORCE_DATA_WIDTH'(exp[c].id));
			if (got.force_vec.fx !== exp[c].force_vec.fx)
				report_mismatch({name, ".fx"}, got.force_vec.fx, exp[c].force_vec.fx);
			if (got.force_vec.fy !== exp[c].force_vec.fy)
				report_mismatch({name, ".fy"}, got.force_vec.fy, exp[c].force_vec.fy);
			if (got.force_vec.fz !== exp[c].force_vec.fz)
				report_mismatch({name, ".fz"}, got.force_vec.fz, exp[c].force_vec.fz);
		end
		@(negedge clk);
		for (int c = 0; c < `NUM_CELLS; c++)
		begin
			if (force_to_mu[c].valid !== 1'b0)
			begin
				$display("force_to_mu[%0d].valid stayed high for more than one cycle", c);
				error_count++;
			end
		end
	endtask

	initial
	begin
		int errors_before;
		logic prev_write;
		void'($urandom(32'hfcb9));
		rst = 1'b1;
		mu_rd_request = '0;
		mu_rd_addr = '0;
		force_wr_enable = '0;
		for (int c = 0; c < `NUM_CELLS; c++)
		begin
			force_and_addr_in[c] = '0;
			for (int a = 0; a < `FORCE_CACHE_DEPTH; a++)
			begin
				model_sum[c][a] = '0;
				model_valid[c][a] = 1'b0;
			end
		end
		error_count = 0;
		failed_tests = 0;
		row_count = 0;

		add_row(1'b1, 4'hf, 5, 0, 0, 0); // nothing written yet.
		add_row(1'b0, 4'h1, 3, 10, -20, 30);
		add_row(1'b1, 4'h1, 3, 0, 0, 0);
		add_row(1'b1, 4'h1, 3, 0, 0, 0);
		add_row(1'b0, 4'h2, 9, 32'h7fffffff, 32'hffffffff, 1);
		add_row(1'b0, 4'h2, 9, 1, 2, 32'hffffffff); // wraps in every lane.
		add_row(1'b0, 4'h2, 9, 0, 0, 0);
		add_row(1'b1, 4'h2, 9, 0, 0, 0);
		add_row(1'b0, 4'hf, 20, 0, 0, 0);
		add_row(1'b0, 4'h5, 20, 100, 200, 300);
		add_row(1'b1, 4'h3, 20, 0, 0, 0);
		add_row(1'b1, 4'hc, 20, 0, 0, 0); // cells 2 and 3 kept their sums.
		add_row(1'b1, 4'hf, 20, 0, 0, 0);
		add_row(1'b0, 4'h1, 0, 0, 0, 0);
		add_row(1'b0, 4'h1, 1, 0, 0, 0);
		add_row(1'b0, 4'h1, 0, 32'h80000000, 32'h80000000, 32'h80000000);
		add_row(1'b1, 4'h1, 1, 0, 0, 0);
		add_row(1'b1, 4'h1, 0, 0, 0, 0);
		for (int k = 0; k < 6; k++)
			add_row(1'b0, 4'h8, 127, 0, 0, 0);
		add_row(1'b1, 4'h8, 127, 0, 0, 0);
		add_row(1'b1, 4'h8, 127, 0, 0, 0);

		repeat (4) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		if (all_force_input_buffer_empty !== 1'b1)
			report_mismatch("all_force_input_buffer_empty",
				`FORCE_DATA_WIDTH'(all_force_input_buffer_empty), 1);
		for (int c = 0; c < `NUM_CELLS; c++)
		begin
			if (force_to_mu[c].valid !== 1'b0)
				report_mismatch($sformatf("force_to_mu[%0d].valid", c),
					`FORCE_DATA_WIDTH'(force_to_mu[c].valid), 0);
		end
		if (error_count != 0)
			failed_tests++;
		$display("reset check: %s", (error_count == 0) ? "ok" : "FAILED");

		prev_write = 1'b0;
		for (int r = 0; r < row_count; r++)
		begin
			errors_before = error_count;
			if (rows[r].is_read)
				apply_read(rows[r], prev_write);
			else
				apply_write(rows[r]);
			prev_write = !rows[r].is_read;
			if (error_count != errors_before)
				failed_tests++;
			$display("row %0d %s mask %h id %0d: %s", r, rows[r].is_read ? "read" : "write",
				rows[r].mask, rows[r].id, (error_count == errors_before) ? "ok" : "FAILED");
		end
		@(posedge clk);
		force_wr_enable <= '0;

		$display("tests run: %0d, tests failed: %0d, errors: %0d", row_count + 1, failed_tests,
			error_count);
		if (error_count == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule
